/* Makefile */
TOP = tb_i3c_ccc_target

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall --top-module i3c_ccc_target -f project.f

clean:
	rm -rf obj_dir

/* project.f */
source/i3c_bus_pkg.sv
source/ccc_pkg.sv
source/ccc_ifs.sv
source/ddr_rx_deser.sv
source/ddr_tx_ack.sv
source/ccc_target_engine.sv
source/ccc_target_regs.sv
source/i3c_ccc_target.sv
sim/tb_i3c_ccc_target.sv

/* sim/tb_i3c_ccc_target.sv */
`timescale 1ns/1ps

module tb_i3c_ccc_target import i3c_bus_pkg::*, ccc_pkg::*; ();

  localparam len_word_t MWL_RST     = 16'h0140;  // Non-default, proves the override
  localparam len_word_t MRL_RST     = 16'h00C0;
  localparam int        TIMEOUT_CYC = 200;       // Per wait, in clock cycles

  typedef struct packed {
    evt_mask_t evt;
    len_word_t mwl;
    len_word_t mrl;
    bus_byte_t rst;
  } regs_t;                             // Register file model

  logic      i_sys_clk;
  logic      i_sys_rst;
  logic      i_engine_en;
  logic      i_sda;
  logic      i_sda_valid;
  logic      o_sda_oe;
  logic      o_sda_out;
  logic      o_engine_done;
  evt_mask_t o_evt_en;
  len_word_t o_mwl;
  len_word_t o_mrl;
  bus_byte_t o_rst_act;

  regs_t model;                         // Expected register state
  string cur_test;                      // Name shown by the compare process
  int    done_cnt;                      // Done pulses seen on the DUT
  int    cmd_cnt;                       // Commands sent
  event  check_ev;

  i3c_ccc_target #(
    .P_MWL_RESET (MWL_RST),
    .P_MRL_RESET (MRL_RST)
  ) UUT (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_sda         (i_sda),
    .i_sda_valid   (i_sda_valid),
    .o_sda_oe      (o_sda_oe),
    .o_sda_out     (o_sda_out),
    .o_engine_done (o_engine_done),
    .o_evt_en      (o_evt_en),
    .o_mwl         (o_mwl),
    .o_mrl         (o_mrl),
    .o_rst_act     (o_rst_act)
  );

  always #5 i_sys_clk = ~i_sys_clk;     // 10 ns period

  always @(negedge i_sys_clk) begin
    if (o_engine_done) begin
      done_cnt++;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_len(input string name, input len_word_t exp, input len_word_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_mask(input string name, input evt_mask_t exp, input evt_mask_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_byte(input string name, input bus_byte_t exp, input bus_byte_t act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("MISMATCH %s ack bit expected %b actual %b", name, exp, act));
    end
  endtask

  // Payload bytes after the code, zero for codes the target ignores
  function automatic int data_bytes(input ccc_code_t code);
    case (code)
      CCC_ENEC_BC, CCC_DISEC_BC, CCC_RSTACT_BC: return 1;
      CCC_SETMWL_BC, CCC_SETMRL_BC:            return 2;
      default:                                 return 0;
    endcase
  endfunction

  // Odd bits to the high parity bit, even bits inverted to the low bit
  function automatic parity_t word_parity(input ccc_code_t code, input bus_byte_t d0,
                                          input bus_byte_t d1, input int nbytes);
    bus_byte_t acc;
    acc = code;
    if (nbytes > 0) acc = acc ^ d0;
    if (nbytes > 1) acc = acc ^ d1;
    return {acc[7] ^ acc[5] ^ acc[3] ^ acc[1], ~(acc[6] ^ acc[4] ^ acc[2] ^ acc[0])};
  endfunction

  // Reference model of one command
  function automatic regs_t apply_ccc(input regs_t cur, input ccc_code_t code,
                                      input bus_byte_t d0, input bus_byte_t d1, input logic ok);
    regs_t nxt;
    nxt = cur;
    if (ok) begin
      case (code)
        CCC_ENEC_BC:   nxt.evt = cur.evt | d0;
        CCC_DISEC_BC:  nxt.evt = cur.evt & ~d0;
        CCC_SETMWL_BC: nxt.mwl = {d0, d1};   // MSB byte first
        CCC_SETMRL_BC: nxt.mrl = {d0, d1};
        CCC_RSTACT_BC: nxt.rst = d0;
        default: ;                           // Unknown code, no change
      endcase
    end
    return nxt;
  endfunction

  function automatic ccc_code_t random_unknown_code();
    ccc_code_t c;
    do begin
      c = ccc_code_t'($urandom);
    end while (data_bytes(c) != 0);
    return c;
  endfunction

  function automatic ccc_code_t pick_code();
    case ($urandom_range(0, 5))
      0:       return CCC_ENEC_BC;
      1:       return CCC_DISEC_BC;
      2:       return CCC_SETMWL_BC;
      3:       return CCC_SETMRL_BC;
      4:       return CCC_RSTACT_BC;
      default: return random_unknown_code();
    endcase
  endfunction

  // One strobed bit after a random idle gap
  task automatic send_bit(input logic b);
    int gap;
    gap = $urandom_range(0, 2);
    repeat (gap) @(posedge i_sys_clk);
    @(posedge i_sys_clk);
    i_sda       <= b;
    i_sda_valid <= 1'b1;
    @(posedge i_sys_clk);               // DUT samples the bit here
    i_sda_valid <= 1'b0;
  endtask

  task automatic send_field(input bus_byte_t value, input int nbits);
    for (int i = nbits - 1; i >= 0; i--) begin
      send_bit(value[i]);               // MSB first
    end
  endtask

  task automatic wait_ack_bit(input string name, output logic bit_val);
    int n;
    n = 0;
    @(negedge i_sys_clk);
    while (!o_sda_oe) begin
      n++;
      if (n > TIMEOUT_CYC) begin
        fail_run($sformatf("%s: target never drove its ACK/NACK bit", name));
      end
      @(negedge i_sys_clk);
    end
    bit_val = o_sda_out;
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    @(negedge i_sys_clk);
    while (!o_engine_done) begin
      n++;
      if (n > TIMEOUT_CYC) begin
        fail_run($sformatf("%s: o_engine_done never pulsed", name));
      end
      @(negedge i_sys_clk);
    end
  endtask

  // Full command frame, optionally with a bad preamble or bad parity
  task automatic run_command(input string name, input ccc_code_t code, input bus_byte_t d0,
                             input bus_byte_t d1, input logic bad_pre, input logic bad_par);
    int        nbytes;
    preamble_t pre;
    parity_t   par;
    logic      ack_bit;
    nbytes = data_bytes(code);
    pre    = CMD_PREAMBLE;
    if (bad_pre) begin
      do begin
        pre = preamble_t'($urandom_range(0, 3));
      end while (pre == CMD_PREAMBLE);
    end
    par = word_parity(code, d0, d1, nbytes);
    if (bad_par) begin
      par = par ^ parity_t'($urandom_range(1, 3));  // Flip one or both bits
    end
    send_field(bus_byte_t'(pre), 2);
    wait_ack_bit(name, ack_bit);
    check_ack(name, bad_pre, ack_bit);  // NACK drives a 1
    if (!bad_pre) begin
      send_field(code, 8);
      if (nbytes > 0) send_field(d0, 8);
      if (nbytes > 1) send_field(d1, 8);
      if (nbytes > 0) send_field(bus_byte_t'(par), 2);
    end
    wait_done(name);
    @(negedge i_sys_clk);               // Last write lands after the done edge
    model = apply_ccc(model, code, d0, d1, !bad_pre && !bad_par);
    cmd_cnt++;
    cur_test = name;
    -> check_ev;
  endtask

  // Compares every register with the model after each command
  always @(check_ev) begin
    check_mask({cur_test, " evt_en"}, model.evt, o_evt_en);
    check_len({cur_test, " mwl"}, model.mwl, o_mwl);
    check_len({cur_test, " mrl"}, model.mrl, o_mrl);
    check_byte({cur_test, " rst_act"}, model.rst, o_rst_act);
  end

  initial begin
    ccc_code_t code;
    bus_byte_t d0;
    bus_byte_t d1;
    logic      bad_pre;
    logic      bad_par;
    void'($urandom(39252));
    i_sys_clk   = 1'b0;
    i_sys_rst   = 1'b0;
    i_engine_en = 1'b0;
    i_sda       = 1'b0;
    i_sda_valid = 1'b0;
    done_cnt    = 0;
    cmd_cnt     = 0;
    model       = '{evt: '0, mwl: MWL_RST, mrl: MRL_RST, rst: '0};
    repeat (2) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;
    repeat (5) @(negedge i_sys_clk);    // Idle, engine still off
    cur_test = "reset";
    -> check_ev;
    if (done_cnt != 0) begin
      fail_run("o_engine_done pulsed with no command sent");
    end
    @(posedge i_sys_clk);
    i_engine_en <= 1'b1;                // Stays high for the rest of the run
    for (int k = 0; k < 4; k++) begin
      run_command("enec", CCC_ENEC_BC, bus_byte_t'($urandom), 8'h00, 1'b0, 1'b0);
      run_command("disec", CCC_DISEC_BC, bus_byte_t'($urandom), 8'h00, 1'b0, 1'b0);
    end
    for (int k = 0; k < 3; k++) begin
      d0 = bus_byte_t'($urandom);
      d1 = bus_byte_t'($urandom);
      run_command("setmwl", CCC_SETMWL_BC, d0, d1, 1'b0, 1'b0);
      d0 = bus_byte_t'($urandom);
      d1 = bus_byte_t'($urandom);
      run_command("setmrl", CCC_SETMRL_BC, d0, d1, 1'b0, 1'b0);
      run_command("rstact", CCC_RSTACT_BC, bus_byte_t'($urandom), 8'h00, 1'b0, 1'b0);
    end
    run_command("bad parity enec", CCC_ENEC_BC, 8'hFF, 8'h00, 1'b0, 1'b1);
    run_command("bad parity setmwl", CCC_SETMWL_BC, 8'h12, 8'h34, 1'b0, 1'b1);
    run_command("bad parity rstact", CCC_RSTACT_BC, 8'h5A, 8'h00, 1'b0, 1'b1);
    run_command("bad preamble", CCC_SETMRL_BC, 8'hAB, 8'hCD, 1'b1, 1'b0);
    run_command("unknown ccc", random_unknown_code(), 8'h00, 8'h00, 1'b0, 1'b0);
    for (int k = 0; k < 200; k++) begin
      code    = pick_code();
      d0      = bus_byte_t'($urandom);
      d1      = bus_byte_t'($urandom);
      bad_pre = ($urandom_range(0, 7) == 0);  // About one frame in eight
      bad_par = ($urandom_range(0, 7) == 0);
      run_command($sformatf("random %0d", k), code, d0, d1, bad_pre, bad_par);
    end
    repeat (4) @(negedge i_sys_clk);
    if (done_cnt != cmd_cnt) begin
      $display("saw %0d done pulses for %0d commands", done_cnt, cmd_cnt);
      $display("Simulation failed");
      $fatal(1, "done pulse count wrong");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* source/ccc_ifs.sv */
`timescale 1ns/1ps

// Engine to deserializer link
interface ccc_rx_if import i3c_bus_pkg::*; ();
  logic      rx_en;                     // Receive enable level
  rx_mode_e  rx_mode;                   // Field to deserialize
  logic      rx_done;                   // Field complete, 1-cycle pulse
  logic      rx_error;                  // Bad preamble or parity, with rx_done
  bus_byte_t rx_byte;                   // Received byte, with rx_done

  modport engine (
    output rx_en, rx_mode,
    input  rx_done, rx_error, rx_byte
  );

  modport deser (
    input  rx_en, rx_mode,
    output rx_done, rx_error, rx_byte
  );
endinterface

// Engine to register file link
interface ccc_regf_if import i3c_bus_pkg::*, ccc_pkg::*; ();
  logic       wr_en;                    // Byte write strobe
  regf_addr_e addr;                     // Target register
  bus_byte_t  wdata;                    // Write byte
  evt_mask_t  evt_en;                   // Current enables, for ENEC/DISEC masks

  modport engine (
    output wr_en, addr, wdata,
    input  evt_en
  );

  modport regs (
    input  wr_en, addr, wdata,
    output evt_en
  );
endinterface

/* source/ccc_pkg.sv */
package ccc_pkg;

  typedef logic [7:0]  ccc_code_t;      // Common Command Code
  typedef logic [15:0] len_word_t;      // MWL and MRL width
  typedef logic [7:0]  evt_mask_t;      // Event enable bits

  // Broadcast codes handled by the target
  localparam ccc_code_t CCC_ENEC_BC   = 8'h00;  // Set event enables
  localparam ccc_code_t CCC_DISEC_BC  = 8'h01;  // Clear event enables
  localparam ccc_code_t CCC_SETMWL_BC = 8'h09;  // Max write length, 2 bytes
  localparam ccc_code_t CCC_SETMRL_BC = 8'h0A;  // Max read length, 2 bytes
  localparam ccc_code_t CCC_RSTACT_BC = 8'h2A;  // Reset action defining byte

  // Byte-wide register file map
  typedef enum logic [2:0] {
    REG_EVT_EN  = 3'd0,                 // Event enable mask
    REG_MWL_HI  = 3'd1,                 // MWL bits 15:8
    REG_MWL_LO  = 3'd2,                 // MWL bits 7:0
    REG_MRL_HI  = 3'd3,                 // MRL bits 15:8
    REG_MRL_LO  = 3'd4,                 // MRL bits 7:0
    REG_RST_ACT = 3'd5                  // Reset action
  } regf_addr_e;

endpackage

/* source/ccc_target_engine.sv */
`timescale 1ns/1ps

module ccc_target_engine import i3c_bus_pkg::*, ccc_pkg::*; (
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_engine_en,
  ccc_rx_if.engine    rx,
  ccc_regf_if.engine  regf,
  output logic        o_tx_en,          // 1-cycle ACK/NACK request
  output logic        o_tx_ack,         // Held response, 1 for ACK
  input  logic        i_tx_done,
  output logic        o_engine_done     // End of command pulse
);

  typedef enum logic [2:0] {
    IDLE, PRE_CMD, ACK, CHECK_CCC, DEF_DATA, CHECK_PARITY, COMMIT
  } state_e;

  state_e     state_q;
  ccc_code_t  code_q;                   // Latched command code
  bus_byte_t  data_q [2];               // Data bytes, MSB byte first
  logic       byte_idx_q;               // Next data slot
  logic       wr_idx_q;                 // Second write issued
  logic       two_bytes;
  logic       first_wr;
  logic       second_wr;
  logic       sel_idx;
  regf_addr_e sel_addr;
  bus_byte_t  sel_data;

  function automatic logic ccc_known(input ccc_code_t code);
    return (code == CCC_ENEC_BC)   || (code == CCC_DISEC_BC) ||
           (code == CCC_SETMWL_BC) || (code == CCC_SETMRL_BC) ||
           (code == CCC_RSTACT_BC);
  endfunction

  assign two_bytes = (code_q == CCC_SETMWL_BC) || (code_q == CCC_SETMRL_BC);
  assign first_wr  = (state_q == CHECK_PARITY) && rx.rx_done && !rx.rx_error;
  assign second_wr = (state_q == COMMIT) && two_bytes && !wr_idx_q;
  assign sel_idx   = (state_q == COMMIT);  // Second write comes from COMMIT

  // Address and byte for the write about to issue
  always_comb begin
    sel_addr = REG_EVT_EN;
    sel_data = data_q[0];
    case (code_q)
      CCC_ENEC_BC:   sel_data = regf.evt_en | data_q[0];   // Set masked bits
      CCC_DISEC_BC:  sel_data = regf.evt_en & ~data_q[0];  // Clear masked bits
      CCC_SETMWL_BC: begin
        sel_addr = sel_idx ? REG_MWL_LO : REG_MWL_HI;
        sel_data = data_q[sel_idx];
      end
      CCC_SETMRL_BC: begin
        sel_addr = sel_idx ? REG_MRL_LO : REG_MRL_HI;
        sel_data = data_q[sel_idx];
      end
      CCC_RSTACT_BC: sel_addr = REG_RST_ACT;
      default: ;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q       <= IDLE;
      rx.rx_en      <= 1'b0;
      rx.rx_mode    <= RX_PREAMBLE;
      o_tx_en       <= 1'b0;
      o_tx_ack      <= 1'b0;
      o_engine_done <= 1'b0;
      regf.wr_en    <= 1'b0;
      byte_idx_q    <= 1'b0;
      wr_idx_q      <= 1'b0;
    end else begin
      o_tx_en       <= 1'b0;            // Pulses by default
      o_engine_done <= 1'b0;
      regf.wr_en    <= 1'b0;
      case (state_q)
        IDLE: begin
          if (i_engine_en) begin
            rx.rx_en   <= 1'b1;
            rx.rx_mode <= RX_PREAMBLE;
            state_q    <= PRE_CMD;
          end
        end
        PRE_CMD: begin
          if (!i_engine_en) begin
            rx.rx_en <= 1'b0;
            state_q  <= IDLE;
          end else if (rx.rx_done) begin
            rx.rx_en <= 1'b0;           // Bus turns around for the ACK bit
            o_tx_en  <= 1'b1;
            o_tx_ack <= !rx.rx_error;   // NACK a foreign preamble
            state_q  <= ACK;
          end
        end
        ACK: begin
          if (i_tx_done) begin
            if (o_tx_ack) begin
              rx.rx_en   <= 1'b1;
              rx.rx_mode <= RX_CCC;
              state_q    <= CHECK_CCC;
            end else begin
              o_engine_done <= 1'b1;
              rx.rx_en      <= i_engine_en;
              rx.rx_mode    <= RX_PREAMBLE;
              state_q       <= i_engine_en ? PRE_CMD : IDLE;
            end
          end
        end
        CHECK_CCC: begin
          if (rx.rx_done) begin
            if (ccc_known(rx.rx_byte)) begin
              rx.rx_mode <= RX_DATA;
              byte_idx_q <= 1'b0;
              state_q    <= DEF_DATA;
            end else begin
              o_engine_done <= 1'b1;    // Unsupported, nothing written
              rx.rx_en      <= i_engine_en;
              rx.rx_mode    <= RX_PREAMBLE;
              state_q       <= i_engine_en ? PRE_CMD : IDLE;
            end
          end
        end
        DEF_DATA: begin
          if (rx.rx_done) begin
            if (two_bytes && !byte_idx_q) begin
              byte_idx_q <= 1'b1;       // Wait for LSB byte
            end else begin
              rx.rx_mode <= RX_PARITY;
              state_q    <= CHECK_PARITY;
            end
          end
        end
        CHECK_PARITY: begin
          if (first_wr) begin
            rx.rx_en      <= 1'b0;
            regf.wr_en    <= 1'b1;
            wr_idx_q      <= 1'b0;
            o_engine_done <= !two_bytes;  // Single write ends here
            state_q       <= COMMIT;
          end else if (rx.rx_done) begin
            o_engine_done <= 1'b1;      // Bad parity drops the command
            rx.rx_en      <= i_engine_en;
            rx.rx_mode    <= RX_PREAMBLE;
            state_q       <= i_engine_en ? PRE_CMD : IDLE;
          end
        end
        COMMIT: begin
          if (second_wr) begin
            regf.wr_en    <= 1'b1;
            wr_idx_q      <= 1'b1;
            o_engine_done <= 1'b1;      // With the last write
          end else begin
            rx.rx_en   <= i_engine_en;
            rx.rx_mode <= RX_PREAMBLE;
            state_q    <= i_engine_en ? PRE_CMD : IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command buffers and write payload
  always_ff @(posedge i_sys_clk) begin
    if (state_q == CHECK_CCC && rx.rx_done) begin
      code_q <= rx.rx_byte;
    end
    if (state_q == DEF_DATA && rx.rx_done) begin
      data_q[byte_idx_q] <= rx.rx_byte;
    end
    if (first_wr || second_wr) begin
      regf.addr  <= sel_addr;
      regf.wdata <= sel_data;
    end
  end

  // Registered writes line up with the COMMIT state
  a_wr_in_commit : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    regf.wr_en |-> (state_q == COMMIT));

endmodule

/* source/ccc_target_regs.sv */
`timescale 1ns/1ps

module ccc_target_regs import i3c_bus_pkg::*, ccc_pkg::*; #(
  parameter len_word_t P_MWL_RESET = 16'd256,
  parameter len_word_t P_MRL_RESET = 16'd256
) (
  input  logic            i_sys_clk,
  input  logic            i_sys_rst,
  ccc_regf_if.regs        regf,
  output evt_mask_t       o_evt_en,
  output len_word_t       o_mwl,
  output len_word_t       o_mrl,
  output bus_byte_t       o_rst_act
);

  evt_mask_t evt_q;                     // Events start disabled
  len_word_t mwl_q;
  len_word_t mrl_q;
  bus_byte_t rst_act_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      evt_q     <= '0;
      mwl_q     <= P_MWL_RESET;
      mrl_q     <= P_MRL_RESET;
      rst_act_q <= '0;
    end else if (regf.wr_en) begin
      case (regf.addr)
        REG_EVT_EN:  evt_q       <= regf.wdata;
        REG_MWL_HI:  mwl_q[15:8] <= regf.wdata;
        REG_MWL_LO:  mwl_q[7:0]  <= regf.wdata;
        REG_MRL_HI:  mrl_q[15:8] <= regf.wdata;
        REG_MRL_LO:  mrl_q[7:0]  <= regf.wdata;
        REG_RST_ACT: rst_act_q   <= regf.wdata;
        default: ;                      // Unmapped, ignored
      endcase
    end
  end

  assign regf.evt_en = evt_q;           // Read back for mask updates
  assign o_evt_en    = evt_q;
  assign o_mwl       = mwl_q;
  assign o_mrl       = mrl_q;
  assign o_rst_act   = rst_act_q;

endmodule

/* source/ddr_rx_deser.sv */
`timescale 1ns/1ps

module ddr_rx_deser import i3c_bus_pkg::*; (
  input  logic    i_sys_clk,
  input  logic    i_sys_rst,
  input  logic    i_sda,                // Sampled bus bit
  input  logic    i_sda_valid,          // One strobe per bit
  ccc_rx_if.deser rx
);

  logic [3:0] bit_cnt_q;                // Bits taken in current field
  bus_byte_t  shift_q;                  // Field shift register
  bus_byte_t  shift_nxt;
  parity_t    par_q;                    // Running XOR over completed bytes
  parity_t    par_exp;                  // Parity the master should send
  parity_t    byte_par;                 // Contribution of the byte now closing
  preamble_t  pre_bits;
  parity_t    par_bits;
  logic       last_bit;
  logic       done_q;
  logic       err_q;
  bus_byte_t  byte_q;

  // Bits per field for each mode
  function automatic logic [3:0] field_len(input rx_mode_e mode);
    if (mode == RX_PREAMBLE || mode == RX_PARITY) begin
      return 4'd2;
    end
    return 4'd8;
  endfunction

  assign shift_nxt = {shift_q[6:0], i_sda};  // MSB arrives first
  assign pre_bits  = shift_nxt[1:0];
  assign par_bits  = shift_nxt[1:0];
  assign byte_par  = {shift_nxt[7] ^ shift_nxt[5] ^ shift_nxt[3] ^ shift_nxt[1],
                      shift_nxt[6] ^ shift_nxt[4] ^ shift_nxt[2] ^ shift_nxt[0]};
  assign par_exp   = {par_q[1], ~par_q[0]};  // Even-bit half is inverted
  assign last_bit  = rx.rx_en && i_sda_valid &&
                     (bit_cnt_q == field_len(rx.rx_mode) - 4'd1);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      bit_cnt_q <= 4'd0;
      par_q     <= '0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      done_q <= last_bit;               // Done lands one cycle after last strobe
      if (!rx.rx_en) begin
        bit_cnt_q <= 4'd0;              // Idle link restarts framing
        par_q     <= '0;
      end else if (i_sda_valid) begin
        if (last_bit) begin
          bit_cnt_q <= 4'd0;
          case (rx.rx_mode)
            RX_PREAMBLE: begin
              err_q <= (pre_bits != CMD_PREAMBLE);
              par_q <= '0;              // New word, new parity
            end
            RX_PARITY: err_q <= (par_bits != par_exp);
            default: begin
              err_q <= 1'b0;
              par_q <= par_q ^ byte_par;
            end
          endcase
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (rx.rx_en && i_sda_valid) begin
      shift_q <= shift_nxt;
    end
    if (last_bit) begin
      byte_q <= (field_len(rx.rx_mode) == 4'd2) ? {6'd0, shift_nxt[1:0]} : shift_nxt;
    end
  end

  assign rx.rx_done  = done_q;
  assign rx.rx_error = err_q;
  assign rx.rx_byte  = byte_q;

  // Engine holds rx_en through the done cycle of every field
  a_done_in_enable : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    rx.rx_done |-> rx.rx_en);

endmodule

/* source/ddr_tx_ack.sv */
`timescale 1ns/1ps

module ddr_tx_ack (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_tx_en,                 // 1-cycle request from engine
  input  logic i_tx_ack,                // 1 for ACK, 0 for NACK
  output logic o_tx_done,
  output logic o_sda_oe,
  output logic o_sda_out
);

  logic oe_q;                           // Bus driven this cycle
  logic nack_q;                         // Bit level, high means NACK

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      oe_q   <= 1'b0;
      nack_q <= 1'b1;                   // Released level
    end else begin
      oe_q <= i_tx_en;                  // Drive for exactly one cycle
      if (i_tx_en) begin
        nack_q <= ~i_tx_ack;
      end
    end
  end

  assign o_sda_oe  = oe_q;
  assign o_tx_done = oe_q;              // Done with the driven bit
  assign o_sda_out = nack_q;            // Low for ACK, high for NACK

  // Engine never requests back-to-back responses
  a_oe_one_cycle : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_sda_oe |=> !o_sda_oe);

endmodule

/* source/i3c_bus_pkg.sv */
package i3c_bus_pkg;

  typedef logic [7:0] bus_byte_t;       // One deserialized bus byte
  typedef logic [1:0] preamble_t;       // Two preamble bits ahead of a word
  typedef logic [1:0] parity_t;         // Two parity bits closing a word

  // Field being deserialized
  typedef enum logic [1:0] {
    RX_PREAMBLE = 2'd0,                 // 2-bit preamble
    RX_CCC      = 2'd1,                 // Command code byte
    RX_DATA     = 2'd2,                 // Defining or data byte
    RX_PARITY   = 2'd3                  // 2-bit parity
  } rx_mode_e;

  // Transmit field kind
  typedef enum logic [0:0] {
    TX_ONE_PREAMBLE = 1'b0              // Single ACK/NACK preamble bit
  } tx_mode_e;

  localparam preamble_t CMD_PREAMBLE = 2'b01;  // Opens a command word

endpackage

/* source/i3c_ccc_target.sv */
`timescale 1ns/1ps

module i3c_ccc_target import i3c_bus_pkg::*, ccc_pkg::*; #(
  parameter len_word_t P_MWL_RESET = 16'd256,
  parameter len_word_t P_MRL_RESET = 16'd256
) (
  input  logic      i_sys_clk,
  input  logic      i_sys_rst,
  input  logic      i_engine_en,
  input  logic      i_sda,
  input  logic      i_sda_valid,
  output logic      o_sda_oe,
  output logic      o_sda_out,
  output logic      o_engine_done,
  output evt_mask_t o_evt_en,
  output len_word_t o_mwl,
  output len_word_t o_mrl,
  output bus_byte_t o_rst_act
);

  logic tx_en;                          // Engine to transmitter
  logic tx_ack;
  logic tx_done;                        // Transmitter back to engine

  ccc_rx_if   rx_link ();
  ccc_regf_if regf_link ();

  ddr_rx_deser u_rx_deser (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_sda       (i_sda),
    .i_sda_valid (i_sda_valid),
    .rx          (rx_link.deser)
  );

  ddr_tx_ack u_tx_ack (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_tx_en   (tx_en),
    .i_tx_ack  (tx_ack),
    .o_tx_done (tx_done),
    .o_sda_oe  (o_sda_oe),
    .o_sda_out (o_sda_out)
  );

  ccc_target_engine u_engine (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .rx            (rx_link.engine),
    .regf          (regf_link.engine),
    .o_tx_en       (tx_en),
    .o_tx_ack      (tx_ack),
    .i_tx_done     (tx_done),
    .o_engine_done (o_engine_done)
  );

  ccc_target_regs #(
    .P_MWL_RESET (P_MWL_RESET),
    .P_MRL_RESET (P_MRL_RESET)
  ) u_regs (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .regf      (regf_link.regs),
    .o_evt_en  (o_evt_en),
    .o_mwl     (o_mwl),
    .o_mrl     (o_mrl),
    .o_rst_act (o_rst_act)
  );

endmodule
